// File: logic/burst_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and size constants for the vector load path.
// Every block names these through burst_pkg:: scoped references.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package burst_pkg;

  // Address and ID sizes
  localparam int unsigned AddrBits = 8;
  localparam int unsigned IdBits   = 4;
  localparam int unsigned BLenBits = 3;
  localparam int unsigned DataBits = 32;
  localparam int unsigned StrbBits = DataBits / 8;

  // Memory depth and number of reorder slots follow from the widths
  localparam int unsigned NumWords = 1 << AddrBits;
  localparam int unsigned NumSlots = 1 << IdBits;

  typedef enum logic {
    OpStore,
    OpLoad
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e               op;
    logic [AddrBits-1:0]   addr;
    logic [BLenBits-1:0]   len;
    logic [DataBits-1:0]   data;
  } cmd_t;

  typedef struct packed {
    logic                  burst;
    logic [BLenBits-1:0]   blen;
  } burst_t;

  typedef struct packed {
    logic [AddrBits-1:0]   addr;
    logic                  write;
    logic [DataBits-1:0]   data;
    logic [StrbBits-1:0]   strb;
    logic [IdBits-1:0]     id;
    burst_t                burst;
  } mem_req_t;

  // One returned word, tagged with its ID
  typedef struct packed {
    logic [IdBits-1:0]     id;
    logic [DataBits-1:0]   data;
  } beat_t;

endpackage

`default_nettype wire

// File: logic/vlsu_burst_issuer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command issuer. Accepts load and store commands, registers
// one memory request per command and hands out word IDs.
// A load is accepted only when enough reorder credits remain.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vlsu_burst_issuer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  burst_pkg::cmd_t     cmd_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  output burst_pkg::mem_req_t req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i,
  input  logic                credit_return_i
);

  // One extra bit so a full count of NumSlots fits
  localparam int unsigned CredBits = burst_pkg::IdBits + 1;

  logic [CredBits-1:0]           credits_q, credits_d;
  logic [CredBits-1:0]           spend;
  logic [burst_pkg::IdBits-1:0]  next_id_q;
  burst_pkg::mem_req_t           req_q, req_d;
  logic                          req_valid_q;
  logic                          is_load;
  logic                          cmd_fire;

  assign is_load = (cmd_i.op == burst_pkg::OpLoad);

  // Stores need no credit, loads need one per word
  assign cmd_ready_o = !req_valid_q &&
                       (!is_load || credits_q >= CredBits'(cmd_i.len));
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  assign spend     = (cmd_fire && is_load) ? CredBits'(cmd_i.len) : '0;
  assign credits_d = credits_q - spend + CredBits'(credit_return_i);

  always_comb begin
    req_d.addr        = cmd_i.addr;
    req_d.write       = !is_load;
    req_d.data        = is_load ? '0 : cmd_i.data;
    req_d.strb        = is_load ? '0 : '1;
    req_d.id          = next_id_q;
    // A single-word load goes out as a plain read
    req_d.burst.burst = is_load && (cmd_i.len > 1);
    req_d.burst.blen  = is_load ? cmd_i.len : '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q   <= CredBits'(burst_pkg::NumSlots);
      next_id_q   <= '0;
      req_valid_q <= 1'b0;
    end else begin
      credits_q <= credits_d;
      if (cmd_fire && is_load) begin
        next_id_q <= next_id_q + burst_pkg::IdBits'(cmd_i.len);
      end
      if (cmd_fire) begin
        req_valid_q <= 1'b1;
      end else if (req_ready_i) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      req_q <= req_d;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

endmodule

`default_nettype wire

// File: logic/burst_cutter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Splits a read burst that crosses a CutLen bank-group border
// into two requests. Other requests pass with zero latency.
// NrCut of 0 turns the block into a plain pass-through.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module burst_cutter #(
  parameter int unsigned CutLen = 4,
  parameter int unsigned NrCut  = 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  burst_pkg::mem_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output burst_pkg::mem_req_t req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i
);

  typedef enum logic {
    Bypass,
    BurstCut
  } cut_state_e;

  cut_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Bypass;
    end else begin
      state_q <= state_d;
    end
  end

  if (NrCut > 1) begin : gen_nrcut_check
    $error("burst_cutter supports only zero or one cut");
  end

  if (NrCut == 0) begin : gen_bypass
    assign req_o       = req_i;
    assign req_valid_o = req_valid_i;
    assign req_ready_o = req_ready_i;
    assign state_d     = Bypass;
  end else begin : gen_cut
    logic [burst_pkg::AddrBits-1:0] bank_offset;
    logic [burst_pkg::AddrBits-1:0] max_blen;
    logic                           crosses;
    // Second part of a cut burst, issued from BurstCut
    burst_pkg::mem_req_t            cut_q, cut_d;

    // Word position inside the bank group and words left to its border
    assign bank_offset = req_i.addr & burst_pkg::AddrBits'(CutLen - 1);
    assign max_blen    = burst_pkg::AddrBits'(CutLen) - bank_offset;
    assign crosses     = burst_pkg::AddrBits'(req_i.burst.blen) > max_blen;

    always_comb begin
      state_d     = state_q;
      cut_d       = cut_q;
      req_o       = req_i;
      req_valid_o = req_valid_i;
      req_ready_o = req_ready_i;

      case (state_q)
        Bypass: begin
          if (req_valid_i && req_i.burst.burst) begin
            if (req_i.write) begin
              // Write bursts are not supported downstream
              req_o.burst = '0;
            end else if (crosses) begin
              // First part runs up to the border
              req_o.burst.blen = burst_pkg::BLenBits'(max_blen);
              req_ready_o      = 1'b0;

              cut_d            = req_i;
              cut_d.addr       = req_i.addr + max_blen;
              cut_d.id         = req_i.id + burst_pkg::IdBits'(max_blen);
              cut_d.burst.blen = req_i.burst.blen - burst_pkg::BLenBits'(max_blen);

              if (req_ready_i) begin
                state_d = BurstCut;
              end
            end
          end
        end

        BurstCut: begin
          req_o       = cut_q;
          req_valid_o = 1'b1;
          // Upstream request retires together with the second part
          req_ready_o = req_ready_i;
          if (req_ready_i) begin
            state_d = Bypass;
          end
        end

        default: begin
          state_d = Bypass;
        end
      endcase
    end

    always_ff @(posedge clk_i) begin
      cut_q <= cut_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/tcdm_bank_group.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank-group memory model. Stores are written on acceptance,
// read bursts stream back one beat per cycle after acceptance.
// A burst is expected to stay inside one bank group.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_group (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  burst_pkg::mem_req_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output burst_pkg::beat_t    beat_o,
  output logic                beat_valid_o
);

  logic [burst_pkg::DataBits-1:0] mem_q [burst_pkg::NumWords];

  // Read burst in progress
  logic [burst_pkg::AddrBits-1:0] rd_addr_q;
  logic [burst_pkg::IdBits-1:0]   rd_id_q;
  logic [burst_pkg::BLenBits-1:0] rd_cnt_q;
  logic [burst_pkg::BLenBits-1:0] req_len;
  logic                           req_fire;

  assign req_ready_o = (rd_cnt_q == '0);
  assign req_fire    = req_valid_i && req_ready_o;

  // A plain read counts as one word
  assign req_len = req_i.burst.burst ? req_i.burst.blen : burst_pkg::BLenBits'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < burst_pkg::NumWords; i++) begin
        mem_q[i] <= '0;
      end
      rd_cnt_q <= '0;
    end else begin
      if (req_fire && req_i.write) begin
        for (int b = 0; b < burst_pkg::StrbBits; b++) begin
          if (req_i.strb[b]) begin
            mem_q[req_i.addr][8*b +: 8] <= req_i.data[8*b +: 8];
          end
        end
      end
      if (req_fire && !req_i.write) begin
        rd_cnt_q <= req_len;
      end else if (rd_cnt_q != '0) begin
        rd_cnt_q <= rd_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire && !req_i.write) begin
      rd_addr_q <= req_i.addr;
      rd_id_q   <= req_i.id;
    end else if (rd_cnt_q != '0) begin
      rd_addr_q <= rd_addr_q + 1'b1;
      rd_id_q   <= rd_id_q + 1'b1;
    end
  end

  assign beat_valid_o = (rd_cnt_q != '0);
  assign beat_o.id    = rd_id_q;
  assign beat_o.data  = mem_q[rd_addr_q];

endmodule

`default_nettype wire

// File: logic/burst_rob.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reorder buffer with one slot per word ID. Beats land at
// their ID, the head releases words in issue order and each
// release hands one credit back to the issuer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module burst_rob (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  burst_pkg::beat_t               beat_i,
  input  logic                           beat_valid_i,
  output logic [burst_pkg::DataBits-1:0] rsp_data_o,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i,
  output logic                           credit_return_o
);

  logic [burst_pkg::DataBits-1:0] slot_data_q [burst_pkg::NumSlots];
  logic [burst_pkg::NumSlots-1:0] slot_valid_q;
  logic [burst_pkg::IdBits-1:0]   head_q;
  logic                           credit_q;
  logic                           release_w;

  assign rsp_valid_o = slot_valid_q[head_q];
  assign rsp_data_o  = slot_data_q[head_q];
  assign release_w   = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= '0;
      head_q       <= '0;
      credit_q     <= 1'b0;
    end else begin
      // Credits keep the incoming ID away from the head slot
      if (release_w) begin
        slot_valid_q[head_q] <= 1'b0;
        head_q               <= head_q + 1'b1;
      end
      if (beat_valid_i) begin
        slot_valid_q[beat_i.id] <= 1'b1;
      end
      credit_q <= release_w;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      slot_data_q[beat_i.id] <= beat_i.data;
    end
  end

  // One pulse per released word, a cycle after the release
  assign credit_return_o = credit_q;

endmodule

`default_nettype wire

// File: logic/burst_load_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the load path: issuer, burst cutter, bank-group
// memory and reorder buffer. CutLen and NrCut are set here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module burst_load_top #(
  parameter int unsigned CutLen = 4,
  parameter int unsigned NrCut  = 1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  burst_pkg::cmd_t                cmd_i,
  input  logic                           cmd_valid_i,
  output logic                           cmd_ready_o,
  output logic [burst_pkg::DataBits-1:0] rsp_data_o,
  output logic                           rsp_valid_o,
  input  logic                           rsp_ready_i
);

  burst_pkg::mem_req_t iss_req, mem_req;
  logic                iss_valid, iss_ready;
  logic                mem_valid, mem_ready;
  burst_pkg::beat_t    beat;
  logic                beat_valid;
  logic                credit_return;

  vlsu_burst_issuer u_issuer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (cmd_i),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_ready_o     (cmd_ready_o),
    .req_o           (iss_req),
    .req_valid_o     (iss_valid),
    .req_ready_i     (iss_ready),
    .credit_return_i (credit_return)
  );

  burst_cutter #(
    .CutLen (CutLen),
    .NrCut  (NrCut)
  ) u_cutter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (iss_req),
    .req_valid_i (iss_valid),
    .req_ready_o (iss_ready),
    .req_o       (mem_req),
    .req_valid_o (mem_valid),
    .req_ready_i (mem_ready)
  );

  tcdm_bank_group u_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (mem_req),
    .req_valid_i  (mem_valid),
    .req_ready_o  (mem_ready),
    .beat_o       (beat),
    .beat_valid_o (beat_valid)
  );

  burst_rob u_rob (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .beat_i          (beat),
    .beat_valid_i    (beat_valid),
    .rsp_data_o      (rsp_data_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .credit_return_o (credit_return)
  );

endmodule

`default_nettype wire

// File: tests/burst_load_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions on the burst cutter output side.
// Bound into every burst_cutter instance of the design.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module burst_load_checker #(
  parameter int unsigned CutLen = 4,
  parameter int unsigned NrCut  = 1
) (
  input logic                clk_i,
  input logic                rst_ni,
  input burst_pkg::mem_req_t cut_req_i,
  input logic                cut_valid_i,
  input logic                cut_ready_i,
  input logic                cut_state_i
);

  int unsigned assert_fails = 0;
  logic [31:0] burst_end;

  // Offset inside the bank group plus the burst length
  assign burst_end = 32'(cut_req_i.addr & burst_pkg::AddrBits'(CutLen - 1)) +
                     32'(cut_req_i.burst.blen);

  held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cut_valid_i && !cut_ready_i |=> cut_valid_i && $stable(cut_req_i))
    else begin
      $error("Cutter output changed while stalled");
      assert_fails++;
    end

  no_cut_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (NrCut == 0) |-> !cut_state_i)
    else begin
      $error("Cutter left Bypass with cutting disabled");
      assert_fails++;
    end

  within_group: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cut_valid_i && cut_req_i.burst.burst && (NrCut != 0) |-> burst_end <= CutLen)
    else begin
      $error("Cutter output burst crosses a bank-group border");
      assert_fails++;
    end

endmodule

bind burst_cutter burst_load_checker #(
  .CutLen (CutLen),
  .NrCut  (NrCut)
) u_checker (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cut_req_i   (req_o),
  .cut_valid_i (req_valid_o),
  .cut_ready_i (req_ready_i),
  .cut_state_i (state_q)
);

`default_nettype wire

// File: tests/burst_load_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watches accepted commands and released responses. Keeps a
// model memory and checks every response word in order.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module burst_load_monitor (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  burst_pkg::cmd_t                cmd_i,
  input  logic                           cmd_valid_i,
  input  logic                           cmd_ready_i,
  input  logic [burst_pkg::DataBits-1:0] rsp_data_i,
  input  logic                           rsp_valid_i,
  input  logic                           rsp_ready_i,
  output int unsigned                    err_count_o,
  output int unsigned                    checked_o,
  output int unsigned                    pending_o
);

  logic [burst_pkg::DataBits-1:0] ref_mem [burst_pkg::NumWords];
  logic [burst_pkg::DataBits-1:0] expected_q [$];

  // Word k of a load, address wraps at the top of memory
  function automatic logic [burst_pkg::DataBits-1:0] expected_word(
    input logic [burst_pkg::AddrBits-1:0] base,
    input int unsigned                    k
  );
    logic [burst_pkg::AddrBits-1:0] addr;
    addr = base + burst_pkg::AddrBits'(k);
    return ref_mem[addr];
  endfunction

  initial begin
    for (int i = 0; i < burst_pkg::NumWords; i++) begin
      ref_mem[i] = '0;
    end
    err_count_o = 0;
    checked_o   = 0;
    pending_o   = 0;
  end

  always @(posedge clk_i) begin
    logic [burst_pkg::DataBits-1:0] exp_word;
    if (rst_ni && rsp_valid_i && rsp_ready_i) begin
      if (expected_q.size() == 0) begin
        $display("[ERROR] %0d ns: response %h with no load word outstanding",
                 $time, rsp_data_i);
        err_count_o = err_count_o + 1;
      end else begin
        exp_word = expected_q.pop_front();
        if (rsp_data_i !== exp_word) begin
          $display("[ERROR] %0d ns: response word %0d is %h, expected %h",
                   $time, checked_o, rsp_data_i, exp_word);
          err_count_o = err_count_o + 1;
        end
        checked_o = checked_o + 1;
      end
    end
    // Memory serves requests in order, so the model updates at acceptance
    if (rst_ni && cmd_valid_i && cmd_ready_i) begin
      if (cmd_i.op == burst_pkg::OpStore) begin
        ref_mem[cmd_i.addr] = cmd_i.data;
      end else begin
        for (int unsigned k = 0; k < cmd_i.len; k++) begin
          expected_q.push_back(expected_word(cmd_i.addr, k));
        end
      end
    end
    pending_o = expected_q.size();
  end

endmodule

`default_nettype wire

// File: tests/tb_burst_load.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the load path. Drives stores and loads, adds
// random response back-pressure and prints the closing report.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_burst_load;

  localparam int unsigned WaitLimit = 400;

  logic                           clk;
  logic                           rst_n;
  burst_pkg::cmd_t                cmd;
  logic                           cmd_valid;
  logic                           cmd_ready;
  logic [burst_pkg::DataBits-1:0] rsp_data;
  logic                           rsp_valid;
  logic                           rsp_ready;
  logic                           ready_random;
  logic [31:0]                    stim_lfsr;
  logic [31:0]                    ready_lfsr;
  int unsigned                    err_count;
  int unsigned                    checked;
  int unsigned                    pending;
  int unsigned                    timeouts;
  int unsigned                    words_issued;

  burst_load_top #(
    .CutLen (4),
    .NrCut  (1)
  ) u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .rsp_data_o  (rsp_data),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  burst_load_monitor u_monitor (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .rsp_data_i  (rsp_data),
    .rsp_valid_i (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .err_count_o (err_count),
    .checked_o   (checked),
    .pending_o   (pending)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Galois LFSR with taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsr_next(state);
    end
  endtask

  task automatic finish_run();
    $display("Report: %0d mismatches, %0d assertion failures, %0d timeouts, %0d of %0d words",
             err_count, u_dut.u_cutter.u_checker.assert_fails, timeouts, checked, words_issued);
    if (err_count == 0 && u_dut.u_cutter.u_checker.assert_fails == 0 && timeouts == 0 &&
        pending == 0 && checked == words_issued) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s did not happen within the wait limit", what);
    timeouts++;
    finish_run();
  endtask

  task automatic send_cmd(input burst_pkg::cmd_op_e op, input logic [7:0] addr,
                          input int unsigned len, input logic [31:0] data);
    int unsigned waited;
    logic        accepted;
    cmd.op    = op;
    cmd.addr  = addr;
    cmd.len   = burst_pkg::BLenBits'(len);
    cmd.data  = data;
    cmd_valid = 1'b1;
    waited    = 0;
    accepted  = 1'b0;
    while (!accepted && waited < WaitLimit) begin
      @(posedge clk);
      accepted = cmd_ready;
      waited++;
      #1;
    end
    cmd_valid = 1'b0;
    if (accepted && op == burst_pkg::OpLoad) begin
      words_issued += len;
    end
    if (!accepted) begin
      report_timeout("command acceptance");
    end
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (pending != 0 && waited < WaitLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pending != 0) begin
      report_timeout("return of all outstanding load words");
    end
  endtask

  // Response ready is random only in the back-pressure phases
  always begin
    logic [31:0] bit_val;
    logic        use_random;
    @(posedge clk);
    use_random = ready_random;
    #1;
    if (use_random) begin
      draw_bits(ready_lfsr, 1, bit_val);
      rsp_ready = bit_val[0];
    end else begin
      rsp_ready = 1'b1;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] len_bits;
    logic [31:0] sel;
    stim_lfsr    = 32'h447ab552;
    ready_lfsr   = 32'h447ab552;
    ready_random = 1'b0;
    timeouts     = 0;
    words_issued = 0;
    rst_n        = 1'b0;
    cmd          = '0;
    cmd_valid    = 1'b0;
    rsp_ready    = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Stores followed by single-word loads and two unwritten words
    for (int a = 0; a < 32; a++) begin
      draw_bits(stim_lfsr, 32, r);
      send_cmd(burst_pkg::OpStore, 8'(a), 1, r);
    end
    for (int a = 0; a < 32; a += 3) begin
      send_cmd(burst_pkg::OpLoad, 8'(a), 1, '0);
    end
    send_cmd(burst_pkg::OpLoad, 8'd100, 1, '0);
    send_cmd(burst_pkg::OpLoad, 8'd200, 1, '0);
    wait_drain();

    // Bursts inside one bank group
    send_cmd(burst_pkg::OpLoad, 8'd8, 4, '0);
    send_cmd(burst_pkg::OpLoad, 8'd9, 3, '0);
    send_cmd(burst_pkg::OpLoad, 8'd22, 2, '0);
    send_cmd(burst_pkg::OpLoad, 8'd28, 4, '0);
    wait_drain();

    // Bursts across a border where the last one wraps past the top of memory
    send_cmd(burst_pkg::OpLoad, 8'd10, 4, '0);
    send_cmd(burst_pkg::OpLoad, 8'd15, 2, '0);
    send_cmd(burst_pkg::OpLoad, 8'd13, 4, '0);
    send_cmd(burst_pkg::OpLoad, 8'd255, 3, '0);
    wait_drain();

    // Back-to-back loads under random back-pressure
    ready_random = 1'b1;
    repeat (40) begin
      draw_bits(stim_lfsr, 5, r);
      draw_bits(stim_lfsr, 2, len_bits);
      send_cmd(burst_pkg::OpLoad, 8'(r), 1 + len_bits, '0);
    end
    wait_drain();

    // Long mixed run in which IDs wrap many times
    repeat (300) begin
      draw_bits(stim_lfsr, 2, sel);
      draw_bits(stim_lfsr, 6, r);
      if (sel == 0) begin
        draw_bits(stim_lfsr, 32, len_bits);
        send_cmd(burst_pkg::OpStore, 8'(r), 1, len_bits);
      end else begin
        draw_bits(stim_lfsr, 2, len_bits);
        send_cmd(burst_pkg::OpLoad, 8'(r), 1 + len_bits, '0);
      end
    end
    ready_random = 1'b0;
    wait_drain();
    // Idle time to catch any stray response
    repeat (20) @(posedge clk);
    #1;
    finish_run();
  end

endmodule

`default_nettype wire

// File: list.f
logic/burst_pkg.sv
logic/vlsu_burst_issuer.sv
logic/burst_cutter.sv
logic/tcdm_bank_group.sv
logic/burst_rob.sv
logic/burst_load_top.sv
tests/burst_load_checker.sv
tests/burst_load_monitor.sv
tests/tb_burst_load.sv
